//--- Makefile
TOP  := tb_rv_frontend
SRCS := $(filter-out +incdir+%,$(shell cat sim.f)) rv_consts.svh

.PHONY: run clean

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): $(SRCS) sim.f
	verilator --binary --timing -j 0 --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir

//--- fetch_window.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module fetch_window (
    input  logic                                CLK,
    input  logic                                RST_N,
    input  logic                                imem_we,
    input  rv_pkg::imem_addr_t                  imem_addr,
    input  rv_pkg::word_t                       imem_wdata,
    input  logic                                start,
    input  rv_pkg::imem_addr_t                  start_pc,
    input  logic                                run,
    output rv_pkg::word_t [`RV_LANES-1:0]       inst_code,
    output logic                                lane_ready
);

    rv_pkg::word_t mem [0:`RV_IMEM_DEPTH-1];
    rv_pkg::imem_addr_t pc;
    logic fetch;

    // start wins over run
    assign fetch = run && !start;

    // load port
    always_ff @(posedge CLK) begin
        if (imem_we) begin
            mem[imem_addr] <= imem_wdata;
        end
    end

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            pc         <= '0;
            lane_ready <= 1'b0;
        end else if (start) begin
            pc         <= start_pc;
            lane_ready <= 1'b0;
        end else if (run) begin
            // wraps at the top of memory
            pc         <= pc + rv_pkg::imem_addr_t'(`RV_LANES);
            lane_ready <= 1'b1;
        end else begin
            lane_ready <= 1'b0;
        end
    end

    // lane k gets word pc + k
    always_ff @(posedge CLK) begin
        if (fetch) begin
            for (int k = 0; k < `RV_LANES; k++) begin
                inst_code[k] <= mem[pc + rv_pkg::imem_addr_t'(k)];
            end
        end
    end

endmodule

`default_nettype wire

//--- operand_read.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module operand_read (
    input  logic                                 CLK,
    input  logic                                 RST_N,
    input  logic                                 lane_ready,
    input  rv_pkg::reg_num_t [`RV_LANES-1:0]     rs1_num,
    input  rv_pkg::reg_num_t [`RV_LANES-1:0]     rs2_num,
    input  rv_pkg::reg_num_t [`RV_LANES-1:0]     rd_num_in,
    input  rv_pkg::csr_num_t [`RV_LANES-1:0]     csr_num_in,
    input  logic                                 wb_en,
    input  rv_pkg::reg_num_t                     wb_num,
    input  rv_pkg::word_t                        wb_data,
    output rv_pkg::word_t [`RV_LANES-1:0]        rs1_val,
    output rv_pkg::word_t [`RV_LANES-1:0]        rs2_val,
    output rv_pkg::reg_num_t [`RV_LANES-1:0]     rd_num,
    output rv_pkg::csr_num_t [`RV_LANES-1:0]     csr_num,
    output logic                                 out_valid
);

    // x0 is not stored
    rv_pkg::word_t regs [1:31];

    // one read port, bypassing the write in the same cycle
    function automatic rv_pkg::word_t read_port(input rv_pkg::reg_num_t num);
        rv_pkg::word_t val;
        if (num == '0) begin
            val = '0;
        end else if (wb_en && wb_num == num) begin
            val = wb_data;
        end else begin
            val = regs[num];
        end
        return val;
    endfunction

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_num != '0) begin
            regs[wb_num] <= wb_data;
        end
    end

    always_ff @(posedge CLK) begin
        for (int k = 0; k < `RV_LANES; k++) begin
            rs1_val[k] <= read_port(rs1_num[k]);
            rs2_val[k] <= read_port(rs2_num[k]);
        end
    end

    // aligned with the decoder's registered outputs
    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            out_valid <= 1'b0;
            rd_num    <= '0;
            csr_num   <= '0;
        end else begin
            out_valid <= lane_ready;
            rd_num    <= rd_num_in;
            csr_num   <= csr_num_in;
        end
    end

endmodule

`default_nettype wire

//--- rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// instructions fetched and decoded per cycle (1, 2 or 4)
`define RV_LANES 2

// instruction memory size in 32-bit words, power of two
`define RV_IMEM_DEPTH 64

// word address width, log2 of the depth
`define RV_IMEM_AW 6

`endif

//--- rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  logic             CLK,
    input  logic             RST_N,
    input  logic             READY,
    input  rv_pkg::word_t    INST_CODE,
    output rv_pkg::reg_num_t RS1_NUM,
    output rv_pkg::reg_num_t RS2_NUM,
    output rv_pkg::reg_num_t RD_NUM,
    output rv_pkg::csr_num_t CSR_NUM,
    output logic [4:0]       CSR_ZIMM,
    output rv_pkg::word_t    IMM,
    output rv_pkg::rv_inst_t INST
);

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_FENCE  = 7'b0001111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic r_type, i_type, s_type, b_type, u_type, j_type;
    logic csr_type, csr_i_type;
    logic alt;
    rv_pkg::word_t imm_d;
    rv_pkg::rv_inst_t inst_d;

    assign opcode = INST_CODE[6:0];
    assign funct3 = INST_CODE[14:12];
    assign funct7 = INST_CODE[31:25];
    // SUB, SRA and SRAI use funct7 0100000
    assign alt    = funct7 == 7'b0100000;

    assign r_type     = opcode == OP_REG;
    assign i_type     = opcode == OP_LOAD || opcode == OP_IMM || opcode == OP_JALR;
    assign s_type     = opcode == OP_STORE;
    assign b_type     = opcode == OP_BRANCH;
    assign u_type     = opcode == OP_LUI || opcode == OP_AUIPC;
    assign j_type     = opcode == OP_JAL;
    // system opcode split by funct3[2] into register and immediate forms
    assign csr_type   = opcode == OP_SYSTEM && !funct3[2];
    assign csr_i_type = opcode == OP_SYSTEM && funct3[2];

    assign RD_NUM  = (READY && (r_type || i_type || u_type || j_type || csr_type || csr_i_type))
                     ? INST_CODE[11:7] : '0;
    assign RS1_NUM = (READY && (r_type || i_type || s_type || b_type || csr_type))
                     ? INST_CODE[19:15] : '0;
    assign RS2_NUM = (READY && (r_type || s_type || b_type)) ? INST_CODE[24:20] : '0;
    assign CSR_NUM = (READY && (csr_type || csr_i_type)) ? INST_CODE[31:20] : '0;

    always_comb begin
        if (opcode == OP_IMM && funct3[1:0] == 2'b01) begin
            // shift amount, zero extended
            imm_d = {27'b0, INST_CODE[24:20]};
        end else if (i_type) begin
            imm_d = {{20{INST_CODE[31]}}, INST_CODE[31:20]};
        end else if (s_type) begin
            imm_d = {{20{INST_CODE[31]}}, funct7, INST_CODE[11:7]};
        end else if (b_type) begin
            imm_d = {{20{INST_CODE[31]}}, INST_CODE[7], INST_CODE[30:25],
                     INST_CODE[11:8], 1'b0};
        end else if (u_type) begin
            imm_d = {INST_CODE[31:12], 12'b0};
        end else if (j_type) begin
            imm_d = {{12{INST_CODE[31]}}, INST_CODE[19:12], INST_CODE[20],
                     INST_CODE[30:21], 1'b0};
        end else begin
            imm_d = '0;
        end
    end

    always_comb begin
        inst_d = '0;
        case (opcode)
            OP_LUI:   inst_d.LUI   = 1'b1;
            OP_AUIPC: inst_d.AUIPC = 1'b1;
            OP_JAL: begin
                inst_d.JAL       = 1'b1;
                inst_d.UPDATE_PC = 1'b1;
            end
            OP_JALR: begin
                inst_d.JALR      = 1'b1;
                inst_d.UPDATE_PC = 1'b1;
            end
            OP_BRANCH: begin
                inst_d.BEQ       = funct3 == 3'b000;
                inst_d.BNE       = funct3 == 3'b001;
                inst_d.BLT       = funct3 == 3'b100;
                inst_d.BGE       = funct3 == 3'b101;
                inst_d.BLTU      = funct3 == 3'b110;
                inst_d.BGEU      = funct3 == 3'b111;
                inst_d.UPDATE_PC = 1'b1;
            end
            OP_LOAD: begin
                inst_d.LB         = funct3 == 3'b000;
                inst_d.LH         = funct3 == 3'b001;
                inst_d.LW         = funct3 == 3'b010;
                inst_d.LBU        = funct3 == 3'b100;
                inst_d.LHU        = funct3 == 3'b101;
                inst_d.ACCESS_MEM = 1'b1;
                // loads stall fetch until the data returns
                inst_d.UPDATE_PC  = 1'b1;
            end
            OP_STORE: begin
                inst_d.SB         = funct3 == 3'b000;
                inst_d.SH         = funct3 == 3'b001;
                inst_d.SW         = funct3 == 3'b010;
                inst_d.ACCESS_MEM = 1'b1;
            end
            OP_IMM: begin
                inst_d.ADDI  = funct3 == 3'b000;
                inst_d.SLTI  = funct3 == 3'b010;
                inst_d.SLTIU = funct3 == 3'b011;
                inst_d.XORI  = funct3 == 3'b100;
                inst_d.ORI   = funct3 == 3'b110;
                inst_d.ANDI  = funct3 == 3'b111;
                inst_d.SLLI  = funct3 == 3'b001 && funct7 == 7'b0;
                inst_d.SRLI  = funct3 == 3'b101 && funct7 == 7'b0;
                inst_d.SRAI  = funct3 == 3'b101 && alt;
            end
            OP_REG: begin
                inst_d.ADD  = funct3 == 3'b000 && funct7 == 7'b0;
                inst_d.SUB  = funct3 == 3'b000 && alt;
                inst_d.SLL  = funct3 == 3'b001 && funct7 == 7'b0;
                inst_d.SLT  = funct3 == 3'b010 && funct7 == 7'b0;
                inst_d.SLTU = funct3 == 3'b011 && funct7 == 7'b0;
                inst_d.XOR  = funct3 == 3'b100 && funct7 == 7'b0;
                inst_d.SRL  = funct3 == 3'b101 && funct7 == 7'b0;
                inst_d.SRA  = funct3 == 3'b101 && alt;
                inst_d.OR   = funct3 == 3'b110 && funct7 == 7'b0;
                inst_d.AND  = funct3 == 3'b111 && funct7 == 7'b0;
            end
            OP_FENCE: begin
                inst_d.FENCE   = funct3 == 3'b000;
                inst_d.FENCE_I = funct3 == 3'b001;
            end
            OP_SYSTEM: begin
                inst_d.ECALL     = funct3 == 3'b000 && INST_CODE[31:20] == 12'h000;
                inst_d.EBREAK    = funct3 == 3'b000 && INST_CODE[31:20] == 12'h001;
                inst_d.CSRRW     = funct3 == 3'b001;
                inst_d.CSRRS     = funct3 == 3'b010;
                inst_d.CSRRC     = funct3 == 3'b011;
                inst_d.CSRRWI    = funct3 == 3'b101;
                inst_d.CSRRSI    = funct3 == 3'b110;
                inst_d.CSRRCI    = funct3 == 3'b111;
                inst_d.UPDATE_PC = funct3 == 3'b000;
            end
            default: ;
        endcase
        inst_d.UPDATE_REG = RD_NUM != '0;
    end

    // everything below reads zero while READY is low
    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            IMM      <= '0;
            CSR_ZIMM <= '0;
            INST     <= '0;
        end else if (READY) begin
            IMM      <= imm_d;
            CSR_ZIMM <= csr_i_type ? INST_CODE[19:15] : 5'b0;
            INST     <= inst_d;
        end else begin
            IMM      <= '0;
            CSR_ZIMM <= '0;
            INST     <= '0;
        end
    end

endmodule

`default_nettype wire

//--- rv_frontend.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_frontend (
    input  logic                                 CLK,
    input  logic                                 RST_N,
    input  logic                                 imem_we,
    input  rv_pkg::imem_addr_t                   imem_addr,
    input  rv_pkg::word_t                        imem_wdata,
    input  logic                                 start,
    input  rv_pkg::imem_addr_t                   start_pc,
    input  logic                                 run,
    input  logic                                 wb_en,
    input  rv_pkg::reg_num_t                     wb_num,
    input  rv_pkg::word_t                        wb_data,
    output rv_pkg::word_t [`RV_LANES-1:0]        imm,
    output logic [`RV_LANES-1:0][4:0]            csr_zimm,
    output rv_pkg::rv_inst_t [`RV_LANES-1:0]     inst,
    output rv_pkg::word_t [`RV_LANES-1:0]        rs1_val,
    output rv_pkg::word_t [`RV_LANES-1:0]        rs2_val,
    output rv_pkg::reg_num_t [`RV_LANES-1:0]     rd_num,
    output rv_pkg::csr_num_t [`RV_LANES-1:0]     csr_num,
    output logic                                 out_valid
);

    rv_pkg::word_t [`RV_LANES-1:0]    inst_code;
    logic                             lane_ready;
    rv_pkg::reg_num_t [`RV_LANES-1:0] dec_rs1;
    rv_pkg::reg_num_t [`RV_LANES-1:0] dec_rs2;
    rv_pkg::reg_num_t [`RV_LANES-1:0] dec_rd;
    rv_pkg::csr_num_t [`RV_LANES-1:0] dec_csr;

    fetch_window fetch_i (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .start      (start),
        .start_pc   (start_pc),
        .run        (run),
        .inst_code  (inst_code),
        .lane_ready (lane_ready)
    );

    for (genvar g = 0; g < `RV_LANES; g++) begin : g_lane
        rv_decode decode_i (
            .CLK       (CLK),
            .RST_N     (RST_N),
            .READY     (lane_ready),
            .INST_CODE (inst_code[g]),
            .RS1_NUM   (dec_rs1[g]),
            .RS2_NUM   (dec_rs2[g]),
            .RD_NUM    (dec_rd[g]),
            .CSR_NUM   (dec_csr[g]),
            .CSR_ZIMM  (csr_zimm[g]),
            .IMM       (imm[g]),
            .INST      (inst[g])
        );
    end

    operand_read opread_i (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .lane_ready (lane_ready),
        .rs1_num    (dec_rs1),
        .rs2_num    (dec_rs2),
        .rd_num_in  (dec_rd),
        .csr_num_in (dec_csr),
        .wb_en      (wb_en),
        .wb_num     (wb_num),
        .wb_data    (wb_data),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .rd_num     (rd_num),
        .csr_num    (csr_num),
        .out_valid  (out_valid)
    );

endmodule

`default_nettype wire

//--- rv_pkg.sv
`default_nettype none

`include "rv_consts.svh"

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_num_t;
    typedef logic [11:0] csr_num_t;
    typedef logic [`RV_IMEM_AW-1:0] imem_addr_t;

    // one flag per decoded instruction, plus pipeline control
    typedef struct packed {
        logic LUI;
        logic AUIPC;
        logic JAL;
        logic JALR;
        logic BEQ;
        logic BNE;
        logic BLT;
        logic BGE;
        logic BLTU;
        logic BGEU;
        logic LB;
        logic LH;
        logic LW;
        logic LBU;
        logic LHU;
        logic SB;
        logic SH;
        logic SW;
        logic ADDI;
        logic SLTI;
        logic SLTIU;
        logic XORI;
        logic ORI;
        logic ANDI;
        logic SLLI;
        logic SRLI;
        logic SRAI;
        logic ADD;
        logic SUB;
        logic SLL;
        logic SLT;
        logic SLTU;
        logic XOR;
        logic SRL;
        logic SRA;
        logic OR;
        logic AND;
        logic FENCE;
        logic FENCE_I;
        logic ECALL;
        logic EBREAK;
        logic CSRRW;
        logic CSRRS;
        logic CSRRC;
        logic CSRRWI;
        logic CSRRSI;
        logic CSRRCI;
        // pipeline control
        logic ACCESS_MEM;
        logic UPDATE_REG;
        logic UPDATE_PC;
    } rv_inst_t;

endpackage

`default_nettype wire

//--- sim.f
+incdir+.
rv_pkg.sv
fetch_window.sv
rv_decode.sv
operand_read.sv
rv_frontend.sv
tb_rv_frontend.sv

//--- tb_rv_frontend.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module tb_rv_frontend;

    localparam int LANES = `RV_LANES;
    localparam int DEPTH = `RV_IMEM_DEPTH;
    localparam int TIMEOUT = 20;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_REG = 7'b0110011;

    logic                             CLK;
    logic                             RST_N;
    logic                             imem_we;
    rv_pkg::imem_addr_t               imem_addr;
    rv_pkg::word_t                    imem_wdata;
    logic                             start;
    rv_pkg::imem_addr_t               start_pc;
    logic                             run;
    logic                             wb_en;
    rv_pkg::reg_num_t                 wb_num;
    rv_pkg::word_t                    wb_data;
    rv_pkg::word_t [LANES-1:0]        imm;
    logic [LANES-1:0][4:0]            csr_zimm;
    rv_pkg::rv_inst_t [LANES-1:0]     inst;
    rv_pkg::word_t [LANES-1:0]        rs1_val;
    rv_pkg::word_t [LANES-1:0]        rs2_val;
    rv_pkg::reg_num_t [LANES-1:0]     rd_num;
    rv_pkg::csr_num_t [LANES-1:0]     csr_num;
    logic                             out_valid;

    // expected decode of each memory word
    rv_pkg::word_t    mem_word [DEPTH];
    rv_pkg::word_t    e_imm [DEPTH];
    rv_pkg::rv_inst_t e_inst [DEPTH];
    rv_pkg::reg_num_t e_rd [DEPTH];
    rv_pkg::reg_num_t e_rs1 [DEPTH];
    rv_pkg::reg_num_t e_rs2 [DEPTH];
    rv_pkg::csr_num_t e_csr [DEPTH];
    logic [4:0]       e_zimm [DEPTH];
    // register file model
    rv_pkg::word_t    regval [32];
    logic [31:0]      seed;
    int               fetched;
    int               fetch_goal;
    logic             fwd_armed;
    rv_pkg::reg_num_t fwd_num;
    rv_pkg::word_t    fwd_data;

    rv_frontend dut_i (.*);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            $display("Errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one clock, inputs change 1 ns after the edge
    task automatic step();
        @(posedge CLK);
        if (run) begin
            fetched++;
        end
        #1;
        wb_en = 1'b0;
        if (fetched >= fetch_goal) begin
            run = 1'b0;
        end
        // write lands on the edge where the first group reads its operands
        if (fwd_armed && fetched == 1) begin
            wb_en           = 1'b1;
            wb_num          = fwd_num;
            wb_data         = fwd_data;
            regval[fwd_num] = fwd_data;
            fwd_armed       = 1'b0;
        end
    endtask

    task automatic write_reg(input rv_pkg::reg_num_t num, input rv_pkg::word_t data);
        wb_en   = 1'b1;
        wb_num  = num;
        wb_data = data;
        if (num != '0) begin
            regval[num] = data;
        end
        step();
    endtask

    task automatic wait_valid(output int cycles);
        cycles = 0;
        do begin
            step();
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("out_valid did not rise within %0d cycles", TIMEOUT);
                $display("Errors found");
                $fatal(1, "timeout");
            end
        end while (!out_valid);
    endtask

    task automatic put(input int a, input rv_pkg::word_t code, input rv_pkg::word_t imm_x,
                       input rv_pkg::rv_inst_t flags, input rv_pkg::reg_num_t rd,
                       input rv_pkg::reg_num_t rs1, input rv_pkg::reg_num_t rs2,
                       input rv_pkg::csr_num_t csr = '0, input logic [4:0] zimm = '0);
        mem_word[a] = code;
        e_imm[a]    = imm_x;
        e_inst[a]   = flags;
        // rd is zero for formats without a destination
        e_inst[a].UPDATE_REG = rd != '0;
        e_rd[a]   = rd;
        e_rs1[a]  = rs1;
        e_rs2[a]  = rs2;
        e_csr[a]  = csr;
        e_zimm[a] = zimm;
    endtask

    // addi x0, x0, addr in every word
    task automatic fill_mem();
        rv_pkg::rv_inst_t nop;
        nop = '{ADDI: 1'b1, default: 1'b0};
        for (int a = 0; a < DEPTH; a++) begin
            put(a, {12'(a), 5'd0, 3'b000, 5'd0, OP_IMM}, 32'(a), nop, '0, '0, '0);
        end
    endtask

    task automatic check_group(input int first);
        int a;
        for (int k = 0; k < LANES; k++) begin
            a = (first + k) % DEPTH;
            check($sformatf("imm[%0d]", k), 64'(imm[k]), 64'(e_imm[a]));
            check($sformatf("inst[%0d]", k), 64'(inst[k]), 64'(e_inst[a]));
            check($sformatf("rd_num[%0d]", k), 64'(rd_num[k]), 64'(e_rd[a]));
            check($sformatf("csr_num[%0d]", k), 64'(csr_num[k]), 64'(e_csr[a]));
            check($sformatf("csr_zimm[%0d]", k), 64'(csr_zimm[k]), 64'(e_zimm[a]));
            check($sformatf("rs1_val[%0d]", k), 64'(rs1_val[k]), 64'(regval[e_rs1[a]]));
            check($sformatf("rs2_val[%0d]", k), 64'(rs2_val[k]), 64'(regval[e_rs2[a]]));
        end
    endtask

    task automatic check_idle();
        check("out_valid", 64'(out_valid), 64'd0);
        for (int k = 0; k < LANES; k++) begin
            check($sformatf("idle imm[%0d]", k), 64'(imm[k]), 64'd0);
            check($sformatf("idle inst[%0d]", k), 64'(inst[k]), 64'd0);
            check($sformatf("idle rd_num[%0d]", k), 64'(rd_num[k]), 64'd0);
            check($sformatf("idle csr_num[%0d]", k), 64'(csr_num[k]), 64'd0);
            check($sformatf("idle csr_zimm[%0d]", k), 64'(csr_zimm[k]), 64'd0);
            check($sformatf("idle rs1_val[%0d]", k), 64'(rs1_val[k]), 64'd0);
            check($sformatf("idle rs2_val[%0d]", k), 64'(rs2_val[k]), 64'd0);
        end
    endtask

    task automatic run_program(input int first, input int groups);
        int lat;
        fetched = 0;
        for (int a = 0; a < DEPTH; a++) begin
            imem_we    = 1'b1;
            imem_addr  = rv_pkg::imem_addr_t'(a);
            imem_wdata = mem_word[a];
            step();
        end
        imem_we  = 1'b0;
        start    = 1'b1;
        start_pc = rv_pkg::imem_addr_t'(first);
        step();
        start      = 1'b0;
        fetch_goal = groups;
        run        = 1'b1;
        for (int g = 0; g < groups; g++) begin
            wait_valid(lat);
            // first group after two edges, then one group per edge
            check("cycles to group", 64'(lat), g == 0 ? 64'd2 : 64'd1);
            check_group(first + g * LANES);
        end
        step();
        check_idle();
    endtask

    task automatic imm_formats();
        rv_pkg::rv_inst_t f;
        logic [11:0] i12;
        logic [11:0] s12;
        logic [12:0] b13;
        logic [19:0] u20;
        logic [20:0] j21;
        i12 = 12'hffb;
        s12 = 12'hf9c;
        b13 = 13'h1ff0;
        u20 = 20'habcde;
        j21 = 21'h1ff800;
        fill_mem();
        f = '{ADDI: 1'b1, default: 1'b0};
        put(0, {i12, 5'd2, 3'b000, 5'd1, OP_IMM}, {{20{i12[11]}}, i12}, f, 5'd1, 5'd2, 5'd0);
        f = '{SW: 1'b1, ACCESS_MEM: 1'b1, default: 1'b0};
        put(1, {s12[11:5], 5'd3, 5'd4, 3'b010, s12[4:0], 7'b0100011}, {{20{s12[11]}}, s12},
            f, 5'd0, 5'd4, 5'd3);
        f = '{BEQ: 1'b1, UPDATE_PC: 1'b1, default: 1'b0};
        put(2, {b13[12], b13[10:5], 5'd6, 5'd5, 3'b000, b13[4:1], b13[11], 7'b1100011},
            {{19{b13[12]}}, b13}, f, 5'd0, 5'd5, 5'd6);
        f = '{LUI: 1'b1, default: 1'b0};
        put(3, {u20, 5'd7, 7'b0110111}, {u20, 12'h000}, f, 5'd7, 5'd0, 5'd0);
        f = '{JAL: 1'b1, UPDATE_PC: 1'b1, default: 1'b0};
        put(4, {j21[20], j21[10:1], j21[11], j21[19:12], 5'd1, 7'b1101111},
            {{11{j21[20]}}, j21}, f, 5'd1, 5'd0, 5'd0);
        // srai x8, x9, 7 takes a zero-extended shift amount
        f = '{SRAI: 1'b1, default: 1'b0};
        put(5, {7'b0100000, 5'd7, 5'd9, 3'b101, 5'd8, OP_IMM}, 32'd7, f, 5'd8, 5'd9, 5'd0);
        run_program(0, 8 / LANES);
    endtask

    task automatic flag_decode();
        rv_pkg::rv_inst_t f;
        fill_mem();
        f = '{LW: 1'b1, ACCESS_MEM: 1'b1, UPDATE_PC: 1'b1, default: 1'b0};
        put(16, {12'd8, 5'd11, 3'b010, 5'd10, 7'b0000011}, 32'd8, f, 5'd10, 5'd11, 5'd0);
        f = '{ECALL: 1'b1, UPDATE_PC: 1'b1, default: 1'b0};
        put(17, {12'h000, 5'd0, 3'b000, 5'd0, 7'b1110011}, 32'd0, f, 5'd0, 5'd0, 5'd0);
        // csrrwi x12, 0x305, 17 in the last word, just before the idle check
        f = '{CSRRWI: 1'b1, default: 1'b0};
        put(23, {12'h305, 5'd17, 3'b101, 5'd12, 7'b1110011}, 32'd0, f, 5'd12, 5'd0, 5'd0,
            12'h305, 5'd17);
        f = '{ADD: 1'b1, default: 1'b0};
        put(19, {7'b0, 5'd15, 5'd14, 3'b000, 5'd13, OP_REG}, 32'd0, f, 5'd13, 5'd14, 5'd15);
        // destination x0, so no register update
        put(20, {7'b0, 5'd2, 5'd1, 3'b000, 5'd0, OP_REG}, 32'd0, f, 5'd0, 5'd1, 5'd2);
        run_program(16, 8 / LANES);
    endtask

    task automatic operand_paths();
        rv_pkg::rv_inst_t f;
        fill_mem();
        write_reg(5'd1, 32'h1111_0001);
        write_reg(5'd2, 32'h2222_0002);
        write_reg(5'd3, 32'h3333_0003);
        write_reg(5'd4, 32'h4444_0004);
        write_reg(5'd5, 32'h5555_0005);
        write_reg(5'd0, 32'hdead_beef);
        f = '{ADD: 1'b1, default: 1'b0};
        put(8, {7'b0, 5'd1, 5'd5, 3'b000, 5'd6, OP_REG}, 32'd0, f, 5'd6, 5'd5, 5'd1);
        put(9, {7'b0, 5'd0, 5'd2, 3'b000, 5'd7, OP_REG}, 32'd0, f, 5'd7, 5'd2, 5'd0);
        put(10, {7'b0, 5'd4, 5'd3, 3'b000, 5'd8, OP_REG}, 32'd0, f, 5'd8, 5'd3, 5'd4);
        put(11, {7'b0, 5'd5, 5'd0, 3'b000, 5'd9, OP_REG}, 32'd0, f, 5'd9, 5'd0, 5'd5);
        // x5 rewritten in the cycle the first group reads it
        fwd_num   = 5'd5;
        fwd_data  = 32'h5a5a_a5a5;
        fwd_armed = 1'b1;
        run_program(8, 4 / LANES);
    endtask

    task automatic random_stream();
        rv_pkg::rv_inst_t f;
        logic [31:0] sel;
        logic [31:0] r;
        for (int i = 1; i < 32; i++) begin
            write_reg(rv_pkg::reg_num_t'(i), next_rand());
        end
        for (int a = 0; a < DEPTH; a++) begin
            sel = next_rand();
            r   = next_rand();
            case (sel[31:30])
                2'b00: begin
                    f = '{ADDI: 1'b1, default: 1'b0};
                    put(a, {r[31:20], r[19:15], 3'b000, r[11:7], OP_IMM},
                        {{20{r[31]}}, r[31:20]}, f, r[11:7], r[19:15], 5'd0);
                end
                2'b01: begin
                    f = '{ADD: 1'b1, default: 1'b0};
                    put(a, {7'b0, r[24:20], r[19:15], 3'b000, r[11:7], OP_REG}, 32'd0, f,
                        r[11:7], r[19:15], r[24:20]);
                end
                default: begin
                    f = '{LUI: 1'b1, default: 1'b0};
                    put(a, {r[31:12], r[11:7], 7'b0110111}, {r[31:12], 12'h000}, f,
                        r[11:7], 5'd0, 5'd0);
                end
            endcase
        end
        // 48 words from 40 runs across the top of memory
        run_program(40, 48 / LANES);
    endtask

    initial begin
        RST_N      = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        start      = 1'b0;
        start_pc   = '0;
        run        = 1'b0;
        wb_en      = 1'b0;
        wb_num     = '0;
        wb_data    = '0;
        seed       = 32'hfb24a395;
        fetched    = 0;
        fetch_goal = 0;
        fwd_armed  = 1'b0;
        fwd_num    = '0;
        fwd_data   = '0;
        for (int i = 0; i < 32; i++) begin
            regval[i] = '0;
        end
        repeat (4) @(posedge CLK);
        #1;
        RST_N = 1'b1;
        check_idle();
        imm_formats();
        flag_decode();
        operand_paths();
        random_stream();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
